//--- logic/cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_WIDTH = 32;                 // Data path width
    localparam int REG_ADDR_W = 5;                  // 32 general purpose registers

    typedef logic [WORD_WIDTH-1:0] word_t;          // One data word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;      // GPR index

    // Memory operation carried in EX/MEM
    typedef enum logic [1:0] {
        MEM_OP_NOP = 2'd0,                          // No memory access
        MEM_OP_LDW = 2'd1,                          // Word load
        MEM_OP_STW = 2'd2                           // Word store
    } mem_op_t;

endpackage

//--- logic/dcache_pkg.sv
package dcache_pkg;

    localparam int LINE_WORDS = 4;                  // Words per cache line
    localparam int WORD_SEL_W = 2;                  // Word offset inside a line

    // 128-bit line, indexable by word offset
    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    // Miss handling states
    typedef enum logic [1:0] {
        DC_IDLE     = 2'd0,                         // Lookup, hits served here
        DC_WB_REQ   = 2'd1,                         // Dirty victim going out
        DC_FILL_REQ = 2'd2                          // Missing line coming in
    } dc_state_t;

endpackage

//--- logic/mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl
    import cpu_pkg::*, dcache_pkg::*;
(
    input  logic                  ex_en,            // EX/MEM entry valid
    input  mem_op_t               ex_mem_op,        // Memory operation
    input  word_t                 ex_mem_wr_data,   // Store data
    input  word_t                 ex_out,           // Byte address or ALU result
    input  line_t                 hit_line,         // Line of the hit way
    output logic                  access,           // Aligned cache access
    output logic                  rw,               // 1 = store
    output logic                  miss_align,       // Low address bits set
    output logic [WORD_SEL_W-1:0] word_sel,         // Word offset in line
    output line_t                 store_line,       // Hit line with store merged
    output word_t                 out               // Stage result
);

    logic is_ld;                                    // Word load decoded
    logic is_st;                                    // Word store decoded
    logic is_mem;                                   // Either memory op

    assign is_ld  = ex_en && (ex_mem_op == MEM_OP_LDW);
    assign is_st  = ex_en && (ex_mem_op == MEM_OP_STW);
    assign is_mem = is_ld || is_st;

    // Word ops need a 4-byte aligned address
    assign miss_align = is_mem && (ex_out[1:0] != 2'b00);
    assign access     = is_mem && !miss_align;      // Misaligned never reaches cache
    assign rw         = is_st;
    assign word_sel   = ex_out[WORD_SEL_W+1:2];     // Bits above the byte offset

    // Store merge, only the addressed word changes
    always_comb begin
        store_line           = hit_line;
        store_line[word_sel] = ex_mem_wr_data;
    end

    // Load picks its word, everything else passes the ALU result
    always_comb begin
        if (is_ld && !miss_align) begin
            out = hit_line[word_sel];
        end else begin
            out = ex_out;
        end
    end

endmodule

//--- logic/dcache_ram.sv
`timescale 1ns/100ps

module dcache_ram
    import dcache_pkg::*;
#(
    parameter  int INDEX_BITS = 8,
    localparam int TAG_BITS   = 30 - INDEX_BITS - 2,
    localparam int SETS       = 1 << INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [INDEX_BITS-1:0] index,        // Set for read and write
    input  logic                  way_we0,
    input  logic                  way_we1,
    input  logic [TAG_BITS-1:0]   wr_tag,
    input  line_t                 wr_line,
    input  logic                  wr_dirty,
    input  logic                  lru_we,
    input  logic                  lru_val,
    output logic [TAG_BITS-1:0]   rd_tag0,
    output logic [TAG_BITS-1:0]   rd_tag1,
    output logic                  rd_valid0,
    output logic                  rd_valid1,
    output logic                  rd_dirty0,
    output logic                  rd_dirty1,
    output line_t                 rd_line0,
    output line_t                 rd_line1,
    output logic                  rd_lru
);

    logic [TAG_BITS-1:0] tag_mem   [2][SETS];   // Per way tags
    line_t               line_mem  [2][SETS];   // Per way data
    logic                dirty_mem [2][SETS];
    logic [1:0][SETS-1:0] valid_q;              // Cleared on reset
    logic [SETS-1:0]     lru_q;                 // One bit per set
    logic [1:0]          way_we;

    assign way_we = {way_we1, way_we0};

    // Tag, line and dirty storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w]) begin
                tag_mem[w][index]   <= wr_tag;
                line_mem[w][index]  <= wr_line;
                dirty_mem[w][index] <= wr_dirty;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way_we[w]) valid_q[w][index] <= 1'b1;
            end
            if (lru_we) lru_q[index] <= lru_val;
        end
    end

    // Combinational read of the addressed set
    assign rd_tag0   = tag_mem[0][index];
    assign rd_tag1   = tag_mem[1][index];
    assign rd_valid0 = valid_q[0][index];
    assign rd_valid1 = valid_q[1][index];
    assign rd_dirty0 = dirty_mem[0][index];
    assign rd_dirty1 = dirty_mem[1][index];
    assign rd_line0  = line_mem[0][index];
    assign rd_line1  = line_mem[1][index];
    assign rd_lru    = lru_q[index];

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter  int INDEX_BITS = 8,                  // Sets = 2**INDEX_BITS
    localparam int TAG_BITS   = 30 - INDEX_BITS - 2 // Word address minus index and offset
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         access,        // Aligned load or store
    input  logic                         rw,            // 1 = store
    input  logic [29:0]                  addr,          // Word address
    input  line_t                        store_line,    // Merged store line
    input  logic [TAG_BITS-1:0]          rd_tag0,
    input  logic [TAG_BITS-1:0]          rd_tag1,
    input  logic                         rd_valid0,
    input  logic                         rd_valid1,
    input  logic                         rd_dirty0,
    input  logic                         rd_dirty1,
    input  line_t                        rd_line0,
    input  line_t                        rd_line1,
    input  logic                         rd_lru,        // Way to replace next
    input  line_t                        l2_rd,         // Refill data
    input  logic                         l2_rdy,        // Transfer done pulse
    output line_t                        hit_line,
    output logic                         miss_stall,
    output logic                         way_we0,
    output logic                         way_we1,
    output logic [TAG_BITS-1:0]          wr_tag,
    output line_t                        wr_line,
    output logic                         wr_dirty,
    output logic                         lru_we,
    output logic                         lru_val,
    output logic                         drq,           // Next level request
    output logic                         drq_we,        // 1 = write-back
    output logic [TAG_BITS+INDEX_BITS-1:0] drq_addr,    // Line address
    output line_t                        drq_wd
);

    dc_state_t             state;                   // Miss FSM
    logic                  drq_q;                   // Request level
    logic                  victim_q;                // Way picked at miss time
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic                  hit0;
    logic                  hit1;
    logic                  hit;
    logic                  miss;
    logic                  victim;                  // Victim for a fresh miss
    logic                  victim_dirty;
    logic                  fill_done;               // Refill arrives this cycle
    logic                  store_hit;

    assign tag   = addr[29:INDEX_BITS+2];
    assign index = addr[INDEX_BITS+1:2];

    // Tag compare on both ways
    assign hit0 = rd_valid0 && (rd_tag0 == tag);
    assign hit1 = rd_valid1 && (rd_tag1 == tag);
    assign hit  = access && (state == DC_IDLE) && (hit0 || hit1);
    assign miss = access && (state == DC_IDLE) && !(hit0 || hit1);

    assign hit_line   = hit1 ? rd_line1 : rd_line0;
    assign miss_stall = miss || (state != DC_IDLE); // Held until refill lands

    // Invalid way first, else LRU
    assign victim       = !rd_valid0 ? 1'b0 : (!rd_valid1 ? 1'b1 : rd_lru);
    assign victim_dirty = victim ? (rd_valid1 && rd_dirty1) : (rd_valid0 && rd_dirty0);

    assign fill_done = (state == DC_FILL_REQ) && drq_q && l2_rdy;
    assign store_hit = hit && rw;

    // Array writes, store hit or refill
    assign way_we0  = (store_hit && !hit1) || (fill_done && !victim_q);
    assign way_we1  = (store_hit && hit1) || (fill_done && victim_q);
    assign wr_tag   = tag;
    assign wr_line  = fill_done ? l2_rd : store_line;
    assign wr_dirty = !fill_done;                   // Refill clean, store dirty

    assign lru_we  = hit;                           // Other way becomes victim
    assign lru_val = !hit1;

    // Next level port, addresses the victim during write-back
    assign drq      = drq_q;
    assign drq_we   = drq_q && (state == DC_WB_REQ);
    assign drq_addr = (state == DC_WB_REQ) ?
                      {(victim_q ? rd_tag1 : rd_tag0), index} : {tag, index};
    assign drq_wd   = victim_q ? rd_line1 : rd_line0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DC_IDLE;
            drq_q    <= 1'b0;
            victim_q <= 1'b0;
        end else begin
            case (state)
                DC_IDLE: begin
                    if (miss) begin
                        victim_q <= victim;         // Fix the way for this miss
                        drq_q    <= 1'b1;
                        state    <= victim_dirty ? DC_WB_REQ : DC_FILL_REQ;
                    end
                end
                DC_WB_REQ: begin
                    if (l2_rdy) begin
                        drq_q <= 1'b0;              // Drop one cycle between transfers
                        state <= DC_FILL_REQ;
                    end
                end
                DC_FILL_REQ: begin
                    if (fill_done) begin
                        drq_q <= 1'b0;
                        state <= DC_IDLE;           // Access hits next cycle
                    end else begin
                        drq_q <= 1'b1;              // Re-raise after write-back
                    end
                end
                default: begin
                    state <= DC_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/mem_reg.sv
`timescale 1ns/100ps

module mem_reg
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,            // Hold MEM/WB
    input  logic      flush,            // Kill MEM/WB
    input  logic      miss_stall,       // Cache busy, insert bubble
    input  logic      miss_align,       // Misaligned access
    input  logic      ex_en,
    input  reg_addr_t ex_dst_addr,
    input  logic      ex_gpr_we_,
    input  word_t     out,              // Stage result
    output logic      mem_en,
    output reg_addr_t mem_dst_addr,
    output logic      mem_gpr_we_,      // Active low
    output word_t     mem_out
);

    logic hold;                         // Keep current contents

    assign hold = stall && !flush && !miss_stall;

    // Control bits, flush first, then miss bubble, then stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_en      <= 1'b0;
            mem_gpr_we_ <= 1'b1;
        end else if (flush || miss_stall) begin
            mem_en      <= 1'b0;        // Bubble
            mem_gpr_we_ <= 1'b1;
        end else if (!stall) begin
            mem_en      <= ex_en;
            mem_gpr_we_ <= miss_align ? 1'b1 : ex_gpr_we_;  // No write on misalign
        end
    end

    // Payload follows unless held
    always_ff @(posedge clk) begin
        if (!hold) begin
            mem_dst_addr <= ex_dst_addr;
            mem_out      <= out;
        end
    end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
    import cpu_pkg::*, dcache_pkg::*;
#(
    parameter  int INDEX_BITS = 8,                  // 256 sets by default
    localparam int TAG_BITS   = 30 - INDEX_BITS - 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        ex_en,                      // EX/MEM register
    input  mem_op_t     ex_mem_op,
    input  word_t       ex_mem_wr_data,
    input  reg_addr_t   ex_dst_addr,
    input  logic        ex_gpr_we_,
    input  word_t       ex_out,                     // Byte address for memory ops
    input  line_t       l2_rd,                      // Next level read line
    input  logic        l2_rdy,
    output logic        miss_stall,
    output word_t       fwd_data,                   // To forwarding unit
    output logic        mem_en,                     // MEM/WB register
    output reg_addr_t   mem_dst_addr,
    output logic        mem_gpr_we_,
    output word_t       mem_out,
    output logic        drq,                        // Next level request
    output logic        drq_we,
    output logic [27:0] drq_addr,
    output line_t       drq_wd
);

    logic                  access;
    logic                  rw;
    logic                  miss_align;
    logic [WORD_SEL_W-1:0] word_sel;
    line_t                 store_line;
    line_t                 hit_line;
    word_t                 out;
    logic [TAG_BITS-1:0]   rd_tag0, rd_tag1, wr_tag;
    logic                  rd_valid0, rd_valid1, rd_dirty0, rd_dirty1, rd_lru;
    line_t                 rd_line0, rd_line1, wr_line;
    logic                  way_we0, way_we1, wr_dirty, lru_we, lru_val;

    assign fwd_data = out;

    mem_ctrl u_mem_ctrl (
        .ex_en(ex_en), .ex_mem_op(ex_mem_op), .ex_mem_wr_data(ex_mem_wr_data),
        .ex_out(ex_out), .hit_line(hit_line), .access(access), .rw(rw),
        .miss_align(miss_align), .word_sel(word_sel), .store_line(store_line), .out(out)
    );

    dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_dcache_ctrl (
        .clk(clk), .rst_n(rst_n), .access(access), .rw(rw),
        .addr({ex_out[31:4], word_sel}),            // Word address
        .store_line(store_line), .rd_tag0(rd_tag0), .rd_tag1(rd_tag1),
        .rd_valid0(rd_valid0), .rd_valid1(rd_valid1), .rd_dirty0(rd_dirty0),
        .rd_dirty1(rd_dirty1), .rd_line0(rd_line0), .rd_line1(rd_line1), .rd_lru(rd_lru),
        .l2_rd(l2_rd), .l2_rdy(l2_rdy), .hit_line(hit_line), .miss_stall(miss_stall),
        .way_we0(way_we0), .way_we1(way_we1), .wr_tag(wr_tag), .wr_line(wr_line),
        .wr_dirty(wr_dirty), .lru_we(lru_we), .lru_val(lru_val), .drq(drq),
        .drq_we(drq_we), .drq_addr(drq_addr), .drq_wd(drq_wd)
    );

    dcache_ram #(.INDEX_BITS(INDEX_BITS)) u_dcache_ram (
        .clk(clk), .rst_n(rst_n),
        .index(ex_out[INDEX_BITS+3:4]),             // Set bits above word offset
        .way_we0(way_we0), .way_we1(way_we1), .wr_tag(wr_tag), .wr_line(wr_line),
        .wr_dirty(wr_dirty), .lru_we(lru_we), .lru_val(lru_val),
        .rd_tag0(rd_tag0), .rd_tag1(rd_tag1), .rd_valid0(rd_valid0), .rd_valid1(rd_valid1),
        .rd_dirty0(rd_dirty0), .rd_dirty1(rd_dirty1), .rd_line0(rd_line0),
        .rd_line1(rd_line1), .rd_lru(rd_lru)
    );

    mem_reg u_mem_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .miss_stall(miss_stall), .miss_align(miss_align), .ex_en(ex_en),
        .ex_dst_addr(ex_dst_addr), .ex_gpr_we_(ex_gpr_we_), .out(out),
        .mem_en(mem_en), .mem_dst_addr(mem_dst_addr), .mem_gpr_we_(mem_gpr_we_),
        .mem_out(mem_out)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);                  // Two cycles in reset
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- sim/mem_stage_assertions.sv
`timescale 1ns/100ps

module mem_stage_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic        drq,
    input logic        l2_rdy,
    input logic [27:0] drq_addr,
    input logic        miss_stall,
    input logic        mem_en,
    input logic        way_we0,
    input logic        way_we1
);

    int fail_cnt = 0;                               // Failed assertion count

    // Request level and address hold until the next level answers
    drq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        drq && !l2_rdy |=> drq && $stable(drq_addr))
        else begin
            fail_cnt++;
            $error("drq fell or drq_addr changed before l2_rdy");
        end

    // Miss cycles only leave bubbles behind
    miss_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        miss_stall |=> !mem_en)
        else begin
            fail_cnt++;
            $error("mem_en high in the cycle after miss_stall");
        end

    // One way written at a time
    one_way_we: assert property (@(posedge clk) disable iff (!rst_n)
        !(way_we0 && way_we1))
        else begin
            fail_cnt++;
            $error("way_we0 and way_we1 high together");
        end

endmodule

bind mem_stage mem_stage_assertions u_assertions (.*);

//--- sim/mem_stage_tb.sv
`timescale 1ns/100ps

module mem_stage_tb
    import cpu_pkg::*, dcache_pkg::*;
;

    localparam int NUM_ACCESSES = 12;               // Cache accesses over all tests
    localparam int WATCHDOG_NS  = (NUM_ACCESSES * 20 + 4) * 10;
    localparam word_t FILL      = 32'hA5A5_0000;

    logic clk, rst_n, stall, flush, ex_en, ex_gpr_we_, l2_rdy;
    logic miss_stall, mem_en, mem_gpr_we_, drq, drq_we;
    mem_op_t ex_mem_op;
    word_t ex_mem_wr_data, ex_out, fwd_data, mem_out, waddr;
    reg_addr_t ex_dst_addr, mem_dst_addr;
    logic [27:0] drq_addr;
    line_t l2_rd, drq_wd, wb_line;                  // wb_line holds last write-back
    word_t ref_mem [word_t];                        // Architected memory view
    word_t backing_mem [word_t];                    // Next level contents
    int seed = 32'h5163_8d14;
    int delay, errors, err_start, tests, total;
    logic saw_miss, saw_drq, saw_wb, drq_any;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    mem_stage #(.INDEX_BITS(4)) dut0 (.*);          // 16 sets give easy conflicts

    function automatic word_t expected_word(input word_t addr);
        if (ref_mem.exists(addr)) return ref_mem[addr];
        return addr ^ FILL;
    endfunction

    function automatic word_t backing_word(input word_t addr);
        if (backing_mem.exists(addr)) return backing_mem[addr];
        return addr ^ FILL;                         // Untouched words keep the fill
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s: %s", name, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_start);
        err_start = errors;
    endtask

    // Called on a falling edge and returns on the falling edge after completion
    task automatic access(input mem_op_t op, input word_t addr, input word_t wdata,
                          input reg_addr_t dst);
        saw_miss       = 1'b0;
        saw_drq        = 1'b0;
        saw_wb         = 1'b0;
        ex_en          = 1'b1;
        ex_mem_op      = op;
        ex_out         = addr;
        ex_mem_wr_data = wdata;
        ex_dst_addr    = dst;
        ex_gpr_we_     = (op == MEM_OP_STW) && (addr[1:0] == 2'b00); // Misaligned asks too
        #1;
        while (miss_stall) begin                    // Inputs held through the miss
            saw_miss = 1'b1;
            @(negedge clk);
            #1;
            saw_drq = saw_drq | drq;
            if (drq && drq_we) begin
                saw_wb  = 1'b1;
                wb_line = drq_wd;
            end
        end
        @(negedge clk);                             // Completion edge has passed
        ex_en     = 1'b0;
        ex_mem_op = MEM_OP_NOP;
        if (op == MEM_OP_STW && addr[1:0] == 2'b00) begin
            ref_mem[addr] = wdata;
        end
    endtask

    // Next level model answers each request after 1 to 4 cycles
    initial begin
        l2_rdy = 1'b0;
        l2_rd  = '0;
        forever begin
            @(negedge clk);
            if (drq) begin
                delay = 1 + ({$random(seed)} % 4);
                repeat (delay - 1) @(negedge clk);
                for (int i = 0; i < LINE_WORDS; i++) begin
                    waddr = {drq_addr, 4'h0} + i * 4;
                    if (drq_we) begin
                        backing_mem[waddr] = drq_wd[i];     // Write-back lands
                    end else begin
                        l2_rd[i] = backing_word(waddr);
                    end
                end
                l2_rdy = 1'b1;
                @(negedge clk);
                l2_rdy = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, accesses did not complete", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        stall = 1'b0;
        flush = 1'b0;
        ex_en = 1'b0;
        ex_mem_op = MEM_OP_NOP;
        ex_mem_wr_data = '0;
        ex_dst_addr = '0;
        ex_gpr_we_ = 1'b1;
        ex_out = '0;
        errors = 0;
        err_start = 0;
        tests = 0;
        @(posedge rst_n);
        @(negedge clk);

        access(MEM_OP_LDW, 32'h0000_1040, '0, 5'd5);        // Cold miss
        check_flag("cold_miss", saw_miss, "no miss_stall on a cold load");
        check_flag("cold_miss", saw_drq && !saw_wb, "no clean refill request seen");
        check_word("cold_miss", expected_word(32'h0000_1040), mem_out);
        end_test("cold_miss");

        access(MEM_OP_STW, 32'h0000_1048, 32'h1234_5678, 5'd0);
        drq_any = saw_drq;
        access(MEM_OP_LDW, 32'h0000_1048, '0, 5'd6);
        check_flag("store_load_hit", !(drq_any || saw_drq), "request issued on a hit");
        check_word("store_load_hit", expected_word(32'h0000_1048), mem_out);
        end_test("store_load_hit");

        access(MEM_OP_LDW, 32'h0000_1140, '0, 5'd7);        // Fills the other way
        access(MEM_OP_LDW, 32'h0000_1240, '0, 5'd8);        // Evicts the dirty line
        check_flag("dirty_evict", saw_wb, "no write-back of the dirty line");
        check_word("dirty_evict", expected_word(32'h0000_1048), wb_line[2]);
        check_word("dirty_evict", expected_word(32'h0000_1240), mem_out);
        access(MEM_OP_LDW, 32'h0000_1048, '0, 5'd9);
        check_word("dirty_evict", expected_word(32'h0000_1048), mem_out);
        end_test("dirty_evict");

        access(MEM_OP_LDW, 32'h0000_1342, '0, 5'd10);       // Line not cached
        check_flag("misaligned", !saw_miss && mem_gpr_we_, "misaligned load not killed");
        access(MEM_OP_STW, 32'h0000_1346, 32'hDEAD_BEEF, 5'd0);
        check_flag("misaligned", !saw_miss && mem_gpr_we_, "misaligned store not killed");
        access(MEM_OP_LDW, 32'h0000_1344, '0, 5'd11);
        check_word("misaligned", expected_word(32'h0000_1344), mem_out);
        end_test("misaligned");

        access(MEM_OP_LDW, 32'h0000_1244, '0, 5'd3);
        stall       = 1'b1;                         // Hit held behind stall
        ex_en       = 1'b1;
        ex_mem_op   = MEM_OP_LDW;
        ex_out      = 32'h0000_124C;
        ex_dst_addr = 5'd7;
        ex_gpr_we_  = 1'b0;
        @(negedge clk);
        check_word("flush_stall", expected_word(32'h0000_1244), mem_out);
        check_word("flush_stall", 32'(5'd3), 32'(mem_dst_addr));
        check_word("flush_stall", expected_word(32'h0000_124C), fwd_data);  // Held load forwards
        stall = 1'b0;
        @(negedge clk);
        check_word("flush_stall", expected_word(32'h0000_124C), mem_out);
        flush       = 1'b1;
        ex_out      = 32'h0000_1248;
        ex_dst_addr = 5'd9;
        @(negedge clk);
        check_flag("flush_stall", !mem_en, "mem_en high after flush");
        flush = 1'b0;
        ex_en = 1'b0;
        ex_mem_op = MEM_OP_NOP;
        end_test("flush_stall");

        repeat (2) @(negedge clk);                  // Let last properties settle
        total = errors + dut0.u_assertions.fail_cnt;
        $display("tests %0d, check errors %0d, assertion failures %0d",
                 tests, errors, dut0.u_assertions.fail_cnt);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- all.f
logic/cpu_pkg.sv
logic/dcache_pkg.sv
logic/mem_ctrl.sv
logic/dcache_ram.sv
logic/dcache_ctrl.sv
logic/mem_reg.sv
logic/mem_stage.sv
sim/tb_clock.sv
sim/mem_stage_assertions.sv
sim/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - logic/cpu_pkg.sv
  - logic/dcache_pkg.sv
  - logic/mem_ctrl.sv
  - logic/dcache_ram.sv
  - logic/dcache_ctrl.sv
  - logic/mem_reg.sv
  - logic/mem_stage.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/mem_stage_assertions.sv
      - sim/mem_stage_tb.sv
